/* bench/engine_forward_vectors.txt */
// Columns: dest hops seq_id data release_delay, all hex
// One input packet per line, sent in file order; hops 0 is dropped
0 3 00 a5a50001 02
1 1 01 a5a50002 03
2 0 02 deadbeef 01
3 f 03 12345678 04
0 2 04 0badf00d 01
0 1 05 cafe0005 20
0 4 06 cafe0006 02
0 2 07 cafe0007 01
0 1 08 cafe0008 01
1 0 09 5a5a0009 01
2 5 0a 5a5a000a 03
3 2 0b 5a5a000b 02
1 3 0c 0f0f000c 05
2 1 0d 0f0f000d 01
3 0 0e 0f0f000e 01
1 2 0f 3c3c000f 02
2 6 10 3c3c0010 04
3 1 11 3c3c0011 01
0 0 12 96960012 01
1 7 13 96960013 03
2 2 14 96960014 18
3 3 15 96960015 01

/* vlog.f */
source/engine_types_pkg.sv
source/bus_types_pkg.sv
source/packet_fifo.sv
source/forward_generator.sv
source/lane_credit_tracker.sv
source/request_issue.sv
source/engine_forward_top.sv
bench/engine_forward_checker.sv
bench/engine_forward_tb.sv

/* Makefile */
# Verilator build and run of the forwarding engine testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f vlog.f --top-module engine_forward_tb -Mdir obj_dir

# Fails on a non-zero exit or on the fail message in the log
run: compile
	./obj_dir/Vengine_forward_tb > run.log 2>&1; status=$$?; cat run.log; \
	test $$status -eq 0 && ! grep -q "TB FAILED" run.log

clean:
	rm -rf obj_dir run.log

/* bench/engine_forward_tb.sv */
/*
 Testbench for the forwarding engine. Sends the vector file packets on the
 input port, acks the output port after random waits and returns lane credits.
*/
module engine_forward_tb
    import engine_types_pkg::*;
    import bus_types_pkg::*;
();

    localparam int NUM_VECTORS     = 22;
    localparam int VEC_COLS        = 5;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * 40 + 200;

    logic        ap_clk;
    logic        areset;
    wb_req_t     in_req;
    wb_rsp_t     in_rsp;
    wb_req_t     out_req;
    wb_rsp_t     out_rsp;
    lane_mask_t  lane_release;
    logic        done;
    logic        end_of_test;
    logic        report_done;
    int          check_count;
    int          error_count;
    logic [31:0] vec_mem [NUM_VECTORS*VEC_COLS];
    int          release_delay [256];
    int          release_due_q [$];
    int          release_lane_q [$];
    int          cycle_num     = 0;
    int          seed          = 32'h0fa2_dbaa;
    int          outputs_acked = 0;
    int          kept_count    = 0;
    int          local_checks  = 0;
    int          local_errors  = 0;

    engine_forward_top uut (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .in_req       (in_req),
        .in_rsp       (in_rsp),
        .out_req      (out_req),
        .out_rsp      (out_rsp),
        .lane_release (lane_release),
        .done         (done)
    );

    engine_forward_checker u_checker (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .in_req       (in_req),
        .in_rsp       (in_rsp),
        .out_req      (out_req),
        .out_rsp      (out_rsp),
        .lane_release (lane_release),
        .num_inputs   (NUM_VECTORS),
        .end_of_test  (end_of_test),
        .report_done  (report_done),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_num <= cycle_num + 1;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    // Columns are dest, hops, seq id, data, release delay
    task automatic load_vectors();
        for (int i = 0; i < NUM_VECTORS; i++) begin
            release_delay[vec_mem[i*VEC_COLS+2][SEQ_W-1:0]] = vec_mem[i*VEC_COLS+4];
            if (vec_mem[i*VEC_COLS+1][HOPS_W-1:0] != '0) begin
                kept_count++;
            end
        end
    endtask

    task automatic check_reset_state();
        local_checks++;
        if (in_rsp.ack || out_req.cyc || out_req.stb || done) begin
            local_errors++;
            $display("Outputs not low in reset: ack %0b cyc %0b stb %0b done %0b",
                     in_rsp.ack, out_req.cyc, out_req.stb, done);
        end else begin
            $display("ok   outputs low in reset");
        end
    endtask

    // Classic write held until ack, next one in the cycle after
    task automatic send_packet(input int idx);
        engine_payload_t pkt;
        pkt.route.dest   = vec_mem[idx*VEC_COLS+0][LANE_W-1:0];
        pkt.route.hops   = vec_mem[idx*VEC_COLS+1][HOPS_W-1:0];
        pkt.route.seq_id = vec_mem[idx*VEC_COLS+2][SEQ_W-1:0];
        pkt.data         = vec_mem[idx*VEC_COLS+3];
        in_req.cyc = 1'b1;
        in_req.stb = 1'b1;
        in_req.we  = 1'b1;
        in_req.dat = pkt;
        do begin
            @(posedge ap_clk);
            #10;
        end while (!in_rsp.ack);
        @(posedge ap_clk);
        #10;
        in_req = '0;
    endtask

    // Due one cycle later than asked, so same-step order never matters
    task automatic schedule_release(input logic [LANE_W-1:0] lane, input int delay);
        release_lane_q.push_back(int'(lane));
        release_due_q.push_back(cycle_num + delay + 1);
    endtask

    // ----------------------------------------------------------------------
    // Output slave and lane release driver
    // ----------------------------------------------------------------------
    initial begin : output_slave
        int              wait_cycles;
        engine_payload_t pkt;
        out_rsp = '0;
        forever begin
            @(posedge ap_clk);
            #10;
            if (out_req.stb) begin
                wait_cycles = $random(seed) & 3;
                repeat (wait_cycles) begin
                    @(posedge ap_clk);
                    #10;
                end
                pkt = engine_payload_t'(out_req.dat);
                out_rsp.ack = 1'b1;
                @(posedge ap_clk);
                #10;
                out_rsp.ack = 1'b0;
                outputs_acked++;
                schedule_release(pkt.route.dest, release_delay[pkt.route.seq_id]);
            end
        end
    end

    // At most one pulse per lane per cycle, the rest wait
    initial begin : release_driver
        lane_mask_t mask;
        lane_release = '0;
        forever begin
            @(posedge ap_clk);
            #10;
            mask = '0;
            for (int i = release_due_q.size() - 1; i >= 0; i--) begin
                if (release_due_q[i] <= cycle_num && !mask[release_lane_q[i]]) begin
                    mask[release_lane_q[i]] = 1'b1;
                    release_due_q.delete(i);
                    release_lane_q.delete(i);
                end
            end
            lane_release = mask;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main_sequence
        areset      = 1'b1;
        in_req      = '0;
        end_of_test = 1'b0;
        $readmemh("bench/engine_forward_vectors.txt", vec_mem);
        load_vectors();
        repeat (10) @(posedge ap_clk);
        #10;
        check_reset_state();
        areset = 1'b0;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            send_packet(i);
        end
        // Drain: every kept packet acked and every credit returned
        while (outputs_acked < kept_count || release_due_q.size() != 0) begin
            @(posedge ap_clk);
            #10;
        end
        while (!done) begin
            @(posedge ap_clk);
            #10;
        end
        local_checks++;
        $display("ok   done high after %0d outputs and their releases", outputs_acked);
        end_of_test = 1'b1;
        while (!report_done) begin
            @(posedge ap_clk);
            #10;
        end
        $display("Summary: %0d checks, %0d errors",
                 check_count + local_checks, error_count + local_errors);
        if (error_count + local_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* bench/engine_forward_checker.sv */
/*
 Scoreboard for the forwarding engine. Predicts forwarded packets from the
 acked inputs, compares every acked output and tracks outstanding lane packets.
*/
module engine_forward_checker
    import engine_types_pkg::*;
    import bus_types_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset,
    input  wb_req_t    in_req,
    input  wb_rsp_t    in_rsp,
    input  wb_req_t    out_req,
    input  wb_rsp_t    out_rsp,
    input  lane_mask_t lane_release,
    input  int         num_inputs,
    input  logic       end_of_test,
    output logic       report_done,
    output int         check_count,
    output int         error_count
);

    engine_payload_t expected_q [$];
    int              inputs_acked;
    int              dropped;
    int              outstanding [NUM_LANES];

    // Zero-hop packets vanish and the rest lose one hop
    task automatic record_input(input engine_payload_t pkt);
        engine_payload_t fwd;
        inputs_acked++;
        if (pkt.route.hops == '0) begin
            dropped++;
        end else begin
            fwd = pkt;
            fwd.route.hops = pkt.route.hops - 1'b1;
            expected_q.push_back(fwd);
        end
    endtask

    // Payload first, then the write cycle framing of the same beat
    task automatic compare_output(input engine_payload_t pkt);
        engine_payload_t exp;
        check_count++;
        if (expected_q.size() == 0) begin
            error_count++;
            $display("Output packet seq %02h arrived when no packet was expected",
                     pkt.route.seq_id);
        end else begin
            exp = expected_q.pop_front();
            if (pkt !== exp) begin
                error_count++;
                $display("FAILED out_req.dat expected %h got %h", exp, pkt);
            end else if (out_req.cyc !== 1'b1 || out_req.we !== 1'b1) begin
                error_count++;
                $display("FAILED out_req.cyc,we expected 1,1 got %h,%h",
                         out_req.cyc, out_req.we);
            end else begin
                $display("ok   packet seq %02h on lane %0d", pkt.route.seq_id, pkt.route.dest);
            end
        end
    endtask

    // Acked outputs minus releases per lane
    task automatic track_credits(input logic acked, input logic [LANE_W-1:0] lane_taken);
        for (int lane = 0; lane < NUM_LANES; lane++) begin
            if (acked && lane_taken == LANE_W'(lane)) begin
                outstanding[lane]++;
            end
            if (lane_release[lane]) begin
                if (outstanding[lane] == 0) begin
                    error_count++;
                    $display("Lane %0d released with no packet outstanding", lane);
                end else begin
                    outstanding[lane]--;
                end
            end
            if (outstanding[lane] > LANE_CREDITS) begin
                error_count++;
                $display("Lane %0d holds %0d packets, more than its %0d credits",
                         lane, outstanding[lane], LANE_CREDITS);
            end
        end
    endtask

    task automatic final_report();
        check_count++;
        if (inputs_acked != num_inputs) begin
            error_count++;
            $display("Only %0d of %0d input packets were acked", inputs_acked, num_inputs);
        end else begin
            $display("ok   all %0d input packets acked, %0d dropped", inputs_acked, dropped);
        end
        check_count++;
        if (expected_q.size() != 0) begin
            error_count++;
            $display("%0d expected packets never left the engine", expected_q.size());
        end else begin
            $display("ok   no expected packet left behind");
        end
    endtask

    // ----------------------------------------------------------------------
    // Sampled on the rising edge before the DUT updates
    // ----------------------------------------------------------------------
    always @(posedge ap_clk) begin : sample
        engine_payload_t out_pkt;
        logic            out_acked;
        out_pkt   = engine_payload_t'(out_req.dat);
        out_acked = out_req.stb && out_rsp.ack;
        if (areset) begin
            report_done = 1'b0;
        end else begin
            if (in_rsp.ack) begin
                record_input(engine_payload_t'(in_req.dat));
            end
            if (out_acked) begin
                compare_output(out_pkt);
            end
            track_credits(out_acked, out_pkt.route.dest);
            if (end_of_test && !report_done) begin
                final_report();
                report_done = 1'b1;
            end
        end
    end

endmodule

/* source/engine_forward_top.sv */
/*
 Forwarding engine top level. Registers the reset, wires the generator, the
 credit tracker and the issue block together, and reports done when drained.
*/
module engine_forward_top
    import engine_types_pkg::*;
    import bus_types_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset,
    input  wb_req_t    in_req,
    output wb_rsp_t    in_rsp,
    output wb_req_t    out_req,
    input  wb_rsp_t    out_rsp,
    input  lane_mask_t lane_release,
    output logic       done
);

    logic           areset_generator;
    engine_packet_t req_head;
    logic           req_pop;
    lane_mask_t     take_lane;
    lane_mask_t     lane_ready;
    logic           generator_idle;
    logic           issue_idle;
    logic           done_q1;
    logic           done_q2;

    // Single reset register fanned out to all blocks
    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    // ----------------------------------------------------------------------
    // Done, two cycles behind the idle flags
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done_q1 <= 1'b0;
            done_q2 <= 1'b0;
        end else begin
            done_q1 <= generator_idle & issue_idle;
            done_q2 <= done_q1;
        end
    end

    assign done = done_q2;

    forward_generator u_forward_generator (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .in_req           (in_req),
        .in_rsp           (in_rsp),
        .req_head         (req_head),
        .req_pop          (req_pop),
        .idle             (generator_idle)
    );

    lane_credit_tracker u_lane_credit_tracker (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .take_lane        (take_lane),
        .lane_release     (lane_release),
        .lane_ready       (lane_ready)
    );

    request_issue u_request_issue (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .req_head         (req_head),
        .lane_ready       (lane_ready),
        .req_pop          (req_pop),
        .take_lane        (take_lane),
        .out_req          (out_req),
        .out_rsp          (out_rsp),
        .idle             (issue_idle)
    );

endmodule

/* source/request_issue.sv */
/*
 Issues the request FIFO head on the Wishbone master port once its lane has
 a credit. Strict order, so a blocked head stalls everything behind it.
*/
module request_issue
    import engine_types_pkg::*;
    import bus_types_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  engine_packet_t req_head,
    input  lane_mask_t     lane_ready,
    output logic           req_pop,
    output lane_mask_t     take_lane,
    output wb_req_t        out_req,
    input  wb_rsp_t        out_rsp,
    output logic           idle
);

    issue_state_t      state_q;
    logic [LANE_W-1:0] dest;
    logic              dest_ready;
    logic              start;
    wb_req_t           out_req_q;

    // ----------------------------------------------------------------------
    // Head decode
    // ----------------------------------------------------------------------
    assign dest       = req_head.payload.route.dest;
    assign dest_ready = lane_ready[dest];

    // Launch from idle or after a credit wait
    assign start = req_head.valid & dest_ready &
                   ((state_q == ISSUE_IDLE) | (state_q == ISSUE_WAIT_CREDIT));

    assign take_lane = start ? (lane_mask_t'(1) << dest) : '0;
    assign req_pop   = (state_q == ISSUE_BUS_CYCLE) & out_rsp.ack;

    // ----------------------------------------------------------------------
    // Issue FSM and bus master
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state_q       <= ISSUE_IDLE;
            out_req_q.cyc <= 1'b0;
            out_req_q.stb <= 1'b0;
            out_req_q.we  <= 1'b0;
        end else begin
            case (state_q)
                ISSUE_IDLE, ISSUE_WAIT_CREDIT: begin
                    if (start) begin
                        state_q       <= ISSUE_BUS_CYCLE;
                        out_req_q.cyc <= 1'b1;
                        out_req_q.stb <= 1'b1;
                        out_req_q.we  <= 1'b1;
                    end else if (req_head.valid) begin
                        state_q <= ISSUE_WAIT_CREDIT;
                    end else begin
                        state_q <= ISSUE_IDLE;
                    end
                end
                ISSUE_BUS_CYCLE: begin
                    // Single-beat cycle ends on ack
                    if (out_rsp.ack) begin
                        state_q       <= ISSUE_IDLE;
                        out_req_q.cyc <= 1'b0;
                        out_req_q.stb <= 1'b0;
                        out_req_q.we  <= 1'b0;
                    end
                end
                default: begin
                    state_q <= ISSUE_IDLE;
                end
            endcase
        end
        if (start) begin
            out_req_q.dat <= req_head.payload;
        end
    end

    assign out_req = out_req_q;
    assign idle    = (state_q == ISSUE_IDLE);

    // The open request carries the head that its ack will pop
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        out_req.stb |-> req_head.valid && out_req.dat == req_head.payload)
        else $error("request_issue: request does not match the FIFO head");

endmodule

/* source/lane_credit_tracker.sv */
/*
 Per-lane credit counters. A credit is taken when the issue block starts a
 bus cycle and returned one cycle after the lane signals a release.
*/
module lane_credit_tracker
    import engine_types_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset_generator,
    input  lane_mask_t take_lane,
    input  lane_mask_t lane_release,
    output lane_mask_t lane_ready
);

    lane_mask_t          release_q;
    logic [CREDIT_W-1:0] credit_q [NUM_LANES];

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            release_q <= '0;
        end else begin
            release_q <= lane_release;
        end
    end

    // ----------------------------------------------------------------------
    // One counter per lane
    // ----------------------------------------------------------------------
    for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
        always_ff @(posedge ap_clk) begin
            if (areset_generator) begin
                credit_q[lane] <= CREDIT_W'(LANE_CREDITS);
            end else begin
                // Take and return together cancel out
                case ({take_lane[lane], release_q[lane]})
                    2'b10:   credit_q[lane] <= credit_q[lane] - 1'b1;
                    2'b01:   credit_q[lane] <= credit_q[lane] + 1'b1;
                    default: credit_q[lane] <= credit_q[lane];
                endcase
            end
        end

        assign lane_ready[lane] = |credit_q[lane];

        assert property (@(posedge ap_clk) disable iff (areset_generator)
            take_lane[lane] |-> credit_q[lane] != '0)
            else $error("lane_credit_tracker: take on lane %0d without credit", lane);
        assert property (@(posedge ap_clk) disable iff (areset_generator)
            release_q[lane] && !take_lane[lane] |-> credit_q[lane] < CREDIT_W'(LANE_CREDITS))
            else $error("lane_credit_tracker: release above limit on lane %0d", lane);
    end

endmodule

/* source/forward_generator.sv */
/*
 Wishbone slave intake, input FIFO, hop-decrement stage and request FIFO.
 The request FIFO head is offered to the issue block and popped on req_pop.
*/
module forward_generator
    import engine_types_pkg::*;
    import bus_types_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  wb_req_t        in_req,
    output wb_rsp_t        in_rsp,
    output engine_packet_t req_head,
    input  logic           req_pop,
    output logic           idle
);

    logic            ack_q;
    engine_payload_t in_dout;
    logic            in_empty;
    logic            in_prog_full;
    logic            in_pop;
    engine_payload_t req_dout;
    logic            req_empty;
    logic            req_prog_full;
    engine_packet_t  stage_q;

    // ----------------------------------------------------------------------
    // Slave intake
    // ----------------------------------------------------------------------
    // One ack per request and none while the input FIFO is nearly full
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= in_req.cyc & in_req.stb & in_req.we & ~ack_q & ~in_prog_full;
        end
    end

    assign in_rsp = '{ack: ack_q};

    packet_fifo input_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .din              (engine_payload_t'(in_req.dat)),
        .wr_en            (ack_q),
        .rd_en            (in_pop),
        .dout             (in_dout),
        .empty            (in_empty),
        .prog_full        (in_prog_full)
    );

    // ----------------------------------------------------------------------
    // Hop stage
    // ----------------------------------------------------------------------
    assign in_pop = ~in_empty & ~req_prog_full;

    always_ff @(posedge ap_clk) begin
        stage_q.payload             <= in_dout;
        stage_q.payload.route.hops  <= in_dout.route.hops - HOPS_W'(1);
        if (areset_generator) begin
            stage_q.valid <= 1'b0;
        end else begin
            // Zero-hop packets end here
            stage_q.valid <= in_pop & (|in_dout.route.hops);
        end
    end

    packet_fifo request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .din              (stage_q.payload),
        .wr_en            (stage_q.valid),
        .rd_en            (req_pop),
        .dout             (req_dout),
        .empty            (req_empty),
        .prog_full        (req_prog_full)
    );

    assign req_head = '{valid: ~req_empty, payload: req_dout};
    assign idle     = in_empty & req_empty & ~stage_q.valid;

    // An acked write is still held on the bus when its payload is pushed
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        in_rsp.ack |-> in_req.cyc && in_req.stb && in_req.we)
        else $error("forward_generator: ack without an open write request");

endmodule

/* source/packet_fifo.sv */
/*
 Synchronous first-word-fall-through FIFO of engine payloads.
 The head shows on dout whenever empty is low; prog_full warns the writer early.
*/
module packet_fifo
    import engine_types_pkg::*;
(
    input  logic            ap_clk,
    input  logic            areset_generator,
    input  engine_payload_t din,
    input  logic            wr_en,
    input  logic            rd_en,
    output engine_payload_t dout,
    output logic            empty,
    output logic            prog_full
);

    engine_payload_t         mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]   wr_ptr_q;
    logic [FIFO_PTR_W-1:0]   rd_ptr_q;
    logic [FIFO_CNT_W-1:0]   count_q;
    logic                    full;

    // Pointers and fill level
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= din;
        end
    end

    assign dout      = mem[rd_ptr_q];
    assign empty     = (count_q == '0);
    assign full      = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
    assign prog_full = (count_q >= FIFO_CNT_W'(PROG_THRESH));

    // Writers must respect prog_full, readers must respect empty
    assert property (@(posedge ap_clk) disable iff (areset_generator) wr_en |-> !full)
        else $error("packet_fifo: write while full");
    assert property (@(posedge ap_clk) disable iff (areset_generator) rd_en |-> !empty)
        else $error("packet_fifo: read while empty");

endmodule

/* source/bus_types_pkg.sv */
/*
 Wishbone classic request and response structs for the engine slave and master ports.
*/
package bus_types_pkg;

    // Payload width on the bus, one full engine payload per beat
    localparam int WB_DAT_W = 46;

    // Destination rides inside dat, so no address field
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic ack;
    } wb_rsp_t;

endpackage

/* source/engine_types_pkg.sv */
/*
 Packet, route and credit types shared by the forwarding engine blocks.
 Import with a wildcard in the module header.
*/
package engine_types_pkg;

    // ----------------------------------------------------------------------
    // Engine sizing
    // ----------------------------------------------------------------------
    localparam int NUM_LANES    = 4;
    localparam int LANE_W       = 2;
    localparam int HOPS_W       = 4;
    localparam int SEQ_W        = 8;
    localparam int DATA_W       = 32;

    // FIFO geometry, depth kept a power of two so the pointers wrap freely
    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W   = FIFO_PTR_W + 1;
    localparam int PROG_THRESH  = 12;

    // Credits per destination lane
    localparam int LANE_CREDITS = 2;
    localparam int CREDIT_W     = 2;

    // ----------------------------------------------------------------------
    // Packet types
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [LANE_W-1:0] dest;
        logic [HOPS_W-1:0] hops;
        logic [SEQ_W-1:0]  seq_id;
    } packet_route_t;

    typedef struct packed {
        packet_route_t     route;
        logic [DATA_W-1:0] data;
    } engine_payload_t;

    typedef struct packed {
        logic            valid;
        engine_payload_t payload;
    } engine_packet_t;

    typedef logic [NUM_LANES-1:0] lane_mask_t;

    typedef enum logic [1:0] {
        ISSUE_IDLE,
        ISSUE_WAIT_CREDIT,
        ISSUE_BUS_CYCLE
    } issue_state_t;

endpackage
